// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_bpu -f bpu.f

run: compile
	@out=$$(./obj_dir/Vtb_bpu); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== bpu.f ====
common/bpu_pkg.sv
logic/inst_decode.sv
predictor/bimodal_table.sv
predictor/btb.sv
logic/pred_select.sv
logic/bpu_top.sv
test/tb_clkgen.sv
test/bpu_monitor.sv
test/bpu_chk.sv
test/tb_bpu.sv

// ==== common/bpu_pkg.sv ====
package bpu_pkg;

    // address and instruction width
    localparam int xlen = 32;

    // control transfer opcodes, rv32i
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // 2-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_weak_nt = 2'b01;  // reset state, weakly not taken

    // one fetched word, read either as a B-type or as a J-type layout
    typedef union packed {
        struct packed {
            logic [6:0] imm_hi;   // imm[12], imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;   // imm[4:1], imm[11]
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;     // imm[20], imm[10:1], imm[11], imm[19:12]
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } inst_u;

endpackage

// ==== logic/bpu_top.sv ====
module bpu_top #(
    parameter int bht_entries = 512,
    parameter int btb_entries = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    input  bpu_pkg::inst_u           if_inst_i,
    input  logic                     ex_branch_valid_i,
    input  logic                     ex_branch_taken_i,
    input  logic [bpu_pkg::xlen-1:0] ex_pc_i,
    input  logic [bpu_pkg::xlen-1:0] ex_target_i,
    output logic                     branch_or_not_o,
    output logic                     pdt_res_o,
    output logic [bpu_pkg::xlen-1:0] pdt_pc_o
);
    import bpu_pkg::*;

    // decode to select
    logic            is_ctrl;
    logic            is_branch;
    logic            is_jal;
    logic [xlen-1:0] br_offset;
    logic [xlen-1:0] jal_offset;

    // tables to select
    logic            taken_pred;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;

    inst_decode inst_decode_inst (
        .if_inst_i    (if_inst_i),
        .is_ctrl_o    (is_ctrl),
        .is_branch_o  (is_branch),
        .is_jal_o     (is_jal),
        .br_offset_o  (br_offset),
        .jal_offset_o (jal_offset)
    );

    bimodal_table #(
        .bht_entries (bht_entries)
    ) bimodal_table_inst (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .taken_pred_o (taken_pred),
        .upd_valid_i  (ex_branch_valid_i),
        .upd_taken_i  (ex_branch_taken_i),
        .upd_pc_i     (ex_pc_i)
    );

    btb #(
        .btb_entries (btb_entries)
    ) btb_inst (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target),
        .upd_valid_i  (ex_branch_valid_i),
        .upd_taken_i  (ex_branch_taken_i),
        .upd_pc_i     (ex_pc_i),
        .upd_target_i (ex_target_i)
    );

    pred_select pred_select_inst (
        .if_pc_i         (if_pc_i),
        .is_ctrl_i       (is_ctrl),
        .is_branch_i     (is_branch),
        .is_jal_i        (is_jal),
        .taken_pred_i    (taken_pred),
        .btb_hit_i       (btb_hit),
        .br_offset_i     (br_offset),
        .jal_offset_i    (jal_offset),
        .btb_target_i    (btb_target),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o)
    );

endmodule

// ==== logic/inst_decode.sv ====
module inst_decode (
    input  bpu_pkg::inst_u                 if_inst_i,
    output logic                           is_ctrl_o,
    output logic                           is_branch_o,
    output logic                           is_jal_o,
    output logic [bpu_pkg::xlen-1:0]       br_offset_o,
    output logic [bpu_pkg::xlen-1:0]       jal_offset_o
);
    import bpu_pkg::*;

    logic is_jalr;

    // opcode sits in the same bits in both views
    assign is_branch_o = (if_inst_i.b.opcode == opc_branch);
    assign is_jal_o    = (if_inst_i.j.opcode == opc_jal);
    assign is_jalr     = (if_inst_i.b.opcode == opc_jalr);

    assign is_ctrl_o = is_branch_o | is_jal_o | is_jalr;

    // B-type offset, 13 bits before sign extension
    assign br_offset_o = {
        {(xlen-13){if_inst_i.b.imm_hi[6]}},
        if_inst_i.b.imm_hi[6],      // imm[12]
        if_inst_i.b.imm_lo[0],      // imm[11]
        if_inst_i.b.imm_hi[5:0],    // imm[10:5]
        if_inst_i.b.imm_lo[4:1],    // imm[4:1]
        1'b0
    };

    // J-type offset, 21 bits before sign extension
    assign jal_offset_o = {
        {(xlen-21){if_inst_i.j.imm[19]}},
        if_inst_i.j.imm[19],        // imm[20]
        if_inst_i.j.imm[7:0],       // imm[19:12]
        if_inst_i.j.imm[8],         // imm[11]
        if_inst_i.j.imm[18:9],      // imm[10:1]
        1'b0
    };

endmodule

// ==== logic/pred_select.sv ====
module pred_select (
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    input  logic                     is_ctrl_i,
    input  logic                     is_branch_i,
    input  logic                     is_jal_i,
    input  logic                     taken_pred_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::xlen-1:0] br_offset_i,
    input  logic [bpu_pkg::xlen-1:0] jal_offset_i,
    input  logic [bpu_pkg::xlen-1:0] btb_target_i,
    output logic                     branch_or_not_o,
    output logic                     pdt_res_o,
    output logic [bpu_pkg::xlen-1:0] pdt_pc_o
);
    import bpu_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] jal_target;

    assign pc_plus4   = if_pc_i + xlen'(4);
    assign br_target  = if_pc_i + br_offset_i;
    assign jal_target = if_pc_i + jal_offset_i;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;  // fall through
        if (is_jal_i) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = 1'b1;  // jal is always taken
            pdt_pc_o        = btb_hit_i ? btb_target_i : jal_target;
        end else if (is_ctrl_i) begin
            // conditional branch or jalr, direction from the counter
            branch_or_not_o = 1'b1;
            pdt_res_o       = taken_pred_i;
            if (taken_pred_i) begin
                if (btb_hit_i) begin
                    pdt_pc_o = btb_target_i;
                end else if (is_branch_i) begin
                    pdt_pc_o = br_target;
                end
                // jalr miss keeps pc+4, register target unknown here
            end
        end
    end

endmodule

// ==== predictor/bimodal_table.sv ====
module bimodal_table #(
    parameter int bht_entries = 512
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    output logic                     taken_pred_o,
    input  logic                     upd_valid_i,
    input  logic                     upd_taken_i,
    input  logic [bpu_pkg::xlen-1:0] upd_pc_i
);
    import bpu_pkg::*;

    localparam int idx_w = $clog2(bht_entries);
    localparam ctr_t ctr_max = 2'b11;
    localparam ctr_t ctr_min = 2'b00;

    ctr_t             ctr_q [bht_entries];
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    ctr_t             wr_old;

    // halfword aligned index, pc[9:1] for 512 entries
    assign rd_idx = if_pc_i[idx_w:1];
    assign wr_idx = upd_pc_i[idx_w:1];

    // msb of the counter is the direction
    assign taken_pred_o = ctr_q[rd_idx][1];

    assign wr_old = ctr_q[wr_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr_q[i] <= ctr_weak_nt;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                if (wr_old != ctr_max) begin
                    ctr_q[wr_idx] <= wr_old + 2'b01;  // step toward taken
                end
            end else begin
                if (wr_old != ctr_min) begin
                    ctr_q[wr_idx] <= wr_old - 2'b01;
                end
            end
        end
    end

endmodule

// ==== predictor/btb.sv ====
module btb #(
    parameter int btb_entries = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    output logic                     btb_hit_o,
    output logic [bpu_pkg::xlen-1:0] btb_target_o,
    input  logic                     upd_valid_i,
    input  logic                     upd_taken_i,
    input  logic [bpu_pkg::xlen-1:0] upd_pc_i,
    input  logic [bpu_pkg::xlen-1:0] upd_target_i
);
    import bpu_pkg::*;

    localparam int idx_w = $clog2(btb_entries);
    localparam int tag_w = xlen - idx_w - 2;

    logic             valid_q  [btb_entries];
    logic [tag_w-1:0] tag_q    [btb_entries];
    logic [xlen-1:0]  target_q [btb_entries];

    logic [idx_w-1:0] rd_idx;
    logic [tag_w-1:0] rd_tag;
    logic [idx_w-1:0] wr_idx;
    logic [tag_w-1:0] wr_tag;
    logic             fill;

    // word aligned index pc[9:2] for 256 entries
    assign rd_idx = if_pc_i[idx_w+1:2];
    assign rd_tag = if_pc_i[xlen-1:idx_w+2];
    assign wr_idx = upd_pc_i[idx_w+1:2];
    assign wr_tag = upd_pc_i[xlen-1:idx_w+2];

    // only taken transfers allocate
    assign fill = upd_valid_i & upd_taken_i;

    assign btb_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign btb_target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target rows written on every fill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd_target_i;  // overwrites any older pc
        end
    end

endmodule

// ==== test/bpu_chk.sv ====
module bpu_chk (
    input logic        clk,
    input logic        rst,
    input logic [31:0] if_pc_i,
    input logic        branch_or_not_o,
    input logic        pdt_res_o,
    input logic [31:0] pdt_pc_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;  // read by the testbench top

    taken_needs_ctrl: assert property (@(posedge clk) disable iff (rst)
        pdt_res_o |-> branch_or_not_o)
        else begin
            fail_cnt++;
            $error("taken prediction on a word that is not a control transfer");
        end

    fallthrough_pc: assert property (@(posedge clk) disable iff (rst)
        !branch_or_not_o |-> (pdt_pc_o == if_pc_i + 32'd4))
        else begin
            fail_cnt++;
            $error("non-control word did not predict pc+4");
        end

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({branch_or_not_o, pdt_res_o, pdt_pc_o}))
        else begin
            fail_cnt++;
            $error("prediction outputs are unknown");
        end

endmodule

bind bpu_top bpu_chk bpu_chk_inst (
    .clk             (clk),
    .rst             (rst),
    .if_pc_i         (if_pc_i),
    .branch_or_not_o (branch_or_not_o),
    .pdt_res_o       (pdt_res_o),
    .pdt_pc_o        (pdt_pc_o)
);

// ==== test/bpu_monitor.sv ====
module bpu_monitor (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        step_valid_i,
    input  logic        done_i,
    input  logic [7:0]  test_i,
    input  logic        exp_bon_i,
    input  logic        exp_res_i,
    input  logic [31:0] exp_pc_i,
    input  logic        act_bon_i,
    input  logic        act_res_i,
    input  logic [31:0] act_pc_i,
    output int          errors_o,
    output logic        report_done_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int err_cnt    = 0;
    int cur_test   = -1;
    int test_errs  = 0;
    int test_cnt   = 0;
    int step_cnt   = 0;

    assign errors_o = err_cnt;

    task automatic close_test();
        if (cur_test >= 0) begin
            test_cnt++;
            if (test_errs == 0) begin
                $display("test %0d ok", cur_test);
            end else begin
                $display("test %0d failed with %0d errors", cur_test, test_errs);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("mismatch at %0t ns: %s expected %0h got %0h",
                     $time, name, exp_v, act_v);
            err_cnt++;
            test_errs++;
        end
    endtask

    // sample late in the cycle, outputs settled
    always @(posedge clk_i) begin
        #38;
        if (step_valid_i && !rst_i) begin
            if (int'(test_i) != cur_test) begin
                close_test();
                cur_test  = int'(test_i);
                test_errs = 0;
            end
            step_cnt++;
            check_value("branch_or_not_o", 32'(exp_bon_i), 32'(act_bon_i));
            check_value("pdt_res_o", 32'(exp_res_i), 32'(act_res_i));
            check_value("pdt_pc_o", exp_pc_i, act_pc_i);
        end
    end

    initial begin
        report_done_o = 1'b0;
        wait (done_i);
        close_test();
        $display("tests %0d, steps %0d, errors %0d", test_cnt, step_cnt, err_cnt);
        report_done_o = 1'b1;
    end

endmodule

// ==== test/bpu_stim.txt ====
// test pc inst upd_valid upd_taken upd_pc upd_target exp_branch exp_taken exp_pc
// all fields hex, one cycle per line, lookup sees the table before this line's update
1 00001000 00100093 0 0 00000000 00000000 0 0 00001004
1 00001000 00000863 0 0 00000000 00000000 1 0 00001004
2 00002000 100000ef 0 0 00000000 00000000 1 1 00002100
2 00003000 ff9ff06f 0 0 00000000 00000000 1 1 00002ff8
3 00004040 00000863 1 1 00004040 00005000 1 0 00004044
3 00004040 00000863 1 1 00004040 00005000 1 1 00005000
3 00004040 00000863 0 0 00000000 00000000 1 1 00005000
3 00004040 00000863 1 0 00004040 00000000 1 1 00005000
3 00004040 00000863 1 0 00004040 00000000 1 1 00005000
3 00004040 00000863 0 0 00000000 00000000 1 0 00004044
4 00006080 fe0000e3 1 1 00006080 00007000 1 0 00006084
4 00006080 fe0000e3 1 1 00006080 00007000 1 1 00007000
4 00006080 fe0000e3 1 1 00006480 00009000 1 1 00007000
4 00006080 fe0000e3 0 0 00000000 00000000 1 1 00006060
5 00008100 00008067 1 1 00008500 0000a000 1 0 00008104
5 00008100 00008067 1 1 00008500 0000a000 1 1 00008104
5 00008100 00008067 1 1 00008100 0000b000 1 1 00008104
5 00008100 00008067 0 0 00000000 00000000 1 1 0000b000
6 0000c200 00000863 1 1 0000c200 0000d000 1 0 0000c204
6 0000c200 00000863 1 1 0000c200 0000d000 1 1 0000d000
6 0000c200 00000863 1 1 0000c200 0000d000 1 1 0000d000
6 0000c200 00000863 1 1 0000c200 0000d000 1 1 0000d000
6 0000c200 00000863 1 0 0000c200 00000000 1 1 0000d000
6 0000c200 00000863 0 0 00000000 00000000 1 1 0000d000

// ==== test/tb_bpu.sv ====
module tb_bpu;
    timeunit 1ns;
    timeprecision 100ps;

    logic            clk;
    logic            rst;
    logic [31:0]     if_pc;
    bpu_pkg::inst_u  if_inst;
    logic            ex_valid;
    logic            ex_taken;
    logic [31:0]     ex_pc;
    logic [31:0]     ex_target;
    logic            branch_or_not;
    logic            pdt_res;
    logic [31:0]     pdt_pc;

    // current step as seen by the monitor
    logic            step_valid;
    logic            done;
    logic [7:0]      cur_test;
    logic            exp_bon;
    logic            exp_res;
    logic [31:0]     exp_pc;
    int              mon_errors;
    logic            report_done;

    // stimulus rows from the file
    logic [31:0] s_test[$];
    logic [31:0] s_pc[$];
    logic [31:0] s_inst[$];
    logic [31:0] s_valid[$];
    logic [31:0] s_taken[$];
    logic [31:0] s_upc[$];
    logic [31:0] s_target[$];
    logic [31:0] s_bon[$];
    logic [31:0] s_res[$];
    logic [31:0] s_epc[$];
    logic        loaded;

    int          fd;
    string       line;
    logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7, f8, f9;

    tb_clkgen #(.period_ns(40), .rst_cycles(16)) tb_clkgen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    bpu_top #(.bht_entries(512), .btb_entries(256)) bpu_top_inst (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pc_i           (ex_pc),
        .ex_target_i       (ex_target),
        .branch_or_not_o   (branch_or_not),
        .pdt_res_o         (pdt_res),
        .pdt_pc_o          (pdt_pc)
    );

    bpu_monitor bpu_monitor_inst (
        .clk_i         (clk),
        .rst_i         (rst),
        .step_valid_i  (step_valid),
        .done_i        (done),
        .test_i        (cur_test),
        .exp_bon_i     (exp_bon),
        .exp_res_i     (exp_res),
        .exp_pc_i      (exp_pc),
        .act_bon_i     (branch_or_not),
        .act_res_i     (pdt_res),
        .act_pc_i      (pdt_pc),
        .errors_o      (mon_errors),
        .report_done_o (report_done)
    );

    task automatic load_stimulus();
        fd = $fopen("test/bpu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/bpu_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // comment and blank lines give fewer than ten fields
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                        f0, f1, f2, f3, f4, f5, f6, f7, f8, f9) == 10) begin
                s_test.push_back(f0);
                s_pc.push_back(f1);
                s_inst.push_back(f2);
                s_valid.push_back(f3);
                s_taken.push_back(f4);
                s_upc.push_back(f5);
                s_target.push_back(f6);
                s_bon.push_back(f7);
                s_res.push_back(f8);
                s_epc.push_back(f9);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        if_pc      = '0;
        if_inst    = '0;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_pc      = '0;
        ex_target  = '0;
        step_valid = 1'b0;
        done       = 1'b0;
        cur_test   = '0;
        exp_bon    = 1'b0;
        exp_res    = 1'b0;
        exp_pc     = '0;
        loaded     = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        @(negedge rst);
        for (int i = 0; i < s_test.size(); i++) begin
            @(posedge clk);
            #2;
            if_pc      = s_pc[i];
            if_inst    = s_inst[i];
            ex_valid   = s_valid[i][0];
            ex_taken   = s_taken[i][0];
            ex_pc      = s_upc[i];
            ex_target  = s_target[i];
            cur_test   = s_test[i][7:0];
            exp_bon    = s_bon[i][0];
            exp_res    = s_res[i][0];
            exp_pc     = s_epc[i];
            step_valid = 1'b1;
        end
        @(posedge clk);
        #2;
        step_valid = 1'b0;
        ex_valid   = 1'b0;
        done       = 1'b1;
        wait (report_done);
        if (mon_errors == 0 && bpu_top_inst.bpu_chk_inst.fail_cnt == 0
            && s_test.size() > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            if (s_test.size() == 0) begin
                $display("no stimulus steps were run");
            end
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // one cycle per step plus reset and some slack
    initial begin
        wait (loaded);
        #((s_test.size() + 16 + 20) * 40);
        $display("timeout, the run did not finish in the expected time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== test/tb_clkgen.sv ====
module tb_clkgen #(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 16
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // release just after an edge, away from sampling
    initial begin
        rst_o = 1'b1;
        repeat (rst_cycles) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule
